// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // core address and instruction widths
    localparam int ADDR_W = 64;
    localparam int INST_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [INST_W-1:0] inst_t;

    // first fetch after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // sequential pc step, no compressed instructions
    localparam addr_t INST_BYTES = 64'd4;

    // lowest jalr target bit, forced to zero
    localparam int JALR_CLR_BIT = 0;

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

    localparam int WB_DAT_W = 64;
    localparam int WB_ADR_W = 64;

    typedef logic [WB_DAT_W-1:0] wb_dat_t;
    // byte address, low bits always zero
    typedef logic [WB_ADR_W-1:0] wb_adr_t;

    // byte offset inside one data word
    localparam wb_adr_t WB_OFFSET_MASK = 64'h7;

    // address bit that picks the upper 32-bit half
    localparam int HALF_SEL_BIT = 2;

    // DROP waits out a cycle whose data is stale
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DROP
    } wb_state_e;

endpackage

// ==== hw/fetch_ifs.sv ====
// pc generator to bus master
interface fetch_req_if;
    logic             req_valid;
    fetch_pkg::addr_t req_pc;
    logic             req_taken;
    logic             flush;

    modport source (
        output req_valid,
        output req_pc,
        output flush,
        input  req_taken
    );

    modport sink (
        input  req_valid,
        input  req_pc,
        input  flush,
        output req_taken
    );
endinterface

// bus master to output register, valid/ready handshake
interface fetch_rsp_if;
    logic             rsp_valid;
    logic             rsp_ready;
    fetch_pkg::inst_t rsp_inst;
    fetch_pkg::addr_t rsp_pc;

    modport source (
        output rsp_valid,
        output rsp_inst,
        output rsp_pc,
        input  rsp_ready
    );

    modport sink (
        input  rsp_valid,
        input  rsp_inst,
        input  rsp_pc,
        output rsp_ready
    );
endinterface

// ==== hw/pc_gen.sv ====
module pc_gen (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             jal_i,
    input  logic             branch_i,
    input  logic             jalr_i,
    input  logic             trap_i,
    input  fetch_pkg::addr_t ex_pc_i,
    input  fetch_pkg::addr_t ex_imm_i,
    input  fetch_pkg::addr_t ex_rs1_i,
    input  fetch_pkg::addr_t ex_alu_res_i,
    input  fetch_pkg::addr_t mtvec_i,
    fetch_req_if.source      req
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t jalr_sum;
    fetch_pkg::addr_t redirect_pc;
    logic             branch_taken;
    logic             redirect;

    // branch compare result comes in as alu difference
    assign branch_taken = branch_i && (ex_alu_res_i == '0);
    assign jalr_sum     = ex_rs1_i + ex_imm_i;

    // jal/branch over jalr over trap
    always_comb begin
        redirect    = 1'b1;
        redirect_pc = ex_pc_i + ex_imm_i;
        if (jal_i || branch_taken) begin
            redirect_pc = ex_pc_i + ex_imm_i;
        end else if (jalr_i) begin
            redirect_pc = jalr_sum;
            redirect_pc[fetch_pkg::JALR_CLR_BIT] = 1'b0;
        end else if (trap_i) begin
            redirect_pc = mtvec_i;
        end else begin
            redirect = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else begin
            if (redirect) begin
                pc_q <= redirect_pc;
            end else if (req.req_taken) begin
                pc_q <= pc_q + fetch_pkg::INST_BYTES;
            end
        end
    end

    // a request stands from the first edge out of reset
    assign req.req_valid = rst_n_i;
    assign req.req_pc    = pc_q;
    // tells the master that anything in flight is wrong-path
    assign req.flush     = redirect;

endmodule

// ==== hw/wb_fetch_master.sv ====
module wb_fetch_master (
    input  logic              clk,
    input  logic              rst_n_i,
    fetch_req_if.sink         req,
    fetch_rsp_if.source       rsp,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output bus_pkg::wb_adr_t  wb_adr_o,
    input  bus_pkg::wb_dat_t  wb_dat_i,
    input  logic              wb_ack_i
);

    bus_pkg::wb_state_e state_q;
    bus_pkg::wb_state_e state_d;
    fetch_pkg::addr_t   cyc_pc_q;
    fetch_pkg::addr_t   rsp_pc_q;
    fetch_pkg::inst_t   rsp_inst_q;
    logic               slot_q;
    logic               take;
    logic               slot_free;
    logic               start;
    logic               capture;

    assign take      = rsp.rsp_valid && rsp.rsp_ready;
    // slot is empty now or will be at this edge
    assign slot_free = !slot_q || take || req.flush;
    assign start     = (state_q == bus_pkg::IDLE) && req.req_valid && slot_free;
    assign capture   = (state_q == bus_pkg::BUSY) && wb_ack_i && !req.flush;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::IDLE: begin
                // a cycle started with a flush is already for the old path
                if (start) begin
                    state_d = req.flush ? bus_pkg::DROP : bus_pkg::BUSY;
                end
            end
            bus_pkg::BUSY: begin
                if (wb_ack_i) begin
                    state_d = bus_pkg::IDLE;
                end else if (req.flush) begin
                    state_d = bus_pkg::DROP;
                end
            end
            bus_pkg::DROP: begin
                // classic cycle cannot be cut short, wait for ack
                if (wb_ack_i) begin
                    state_d = bus_pkg::IDLE;
                end
            end
            default: begin
                state_d = bus_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= bus_pkg::IDLE;
            slot_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                slot_q <= 1'b1;
            end else if (take || req.flush) begin
                slot_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cyc_pc_q <= req.req_pc;
        end
        if (capture) begin
            rsp_pc_q   <= cyc_pc_q;
            rsp_inst_q <= cyc_pc_q[bus_pkg::HALF_SEL_BIT] ? wb_dat_i[63:32] : wb_dat_i[31:0];
        end
    end

    assign req.req_taken = start;

    assign wb_cyc_o = (state_q != bus_pkg::IDLE);
    assign wb_stb_o = (state_q != bus_pkg::IDLE);
    assign wb_adr_o = cyc_pc_q & ~bus_pkg::WB_OFFSET_MASK;

    // held response turns stale on a redirect
    assign rsp.rsp_valid = slot_q && !req.flush;
    assign rsp.rsp_inst  = rsp_inst_q;
    assign rsp.rsp_pc    = rsp_pc_q;

endmodule

// ==== hw/fetch_out.sv ====
module fetch_out (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    fetch_rsp_if.sink        rsp,
    output fetch_pkg::inst_t inst_o,
    output fetch_pkg::addr_t inst_pc_o,
    output logic             inst_valid_o
);

    fetch_pkg::inst_t inst_q;
    fetch_pkg::addr_t pc_q;
    logic             valid_q;
    logic             take;

    // whole register freezes under stall, valid entry or not
    assign rsp.rsp_ready = !stall_i;
    assign take          = rsp.rsp_valid && rsp.rsp_ready;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            // each response shows for exactly one unstalled cycle
            valid_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            inst_q <= rsp.rsp_inst;
            pc_q   <= rsp.rsp_pc;
        end
    end

    assign inst_o       = inst_q;
    assign inst_pc_o    = pc_q;
    assign inst_valid_o = valid_q;

endmodule

// ==== hw/ifetch_top.sv ====
module ifetch_top (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             jal_i,
    input  logic             branch_i,
    input  logic             jalr_i,
    input  logic             trap_i,
    input  fetch_pkg::addr_t ex_pc_i,
    input  fetch_pkg::addr_t ex_imm_i,
    input  fetch_pkg::addr_t ex_rs1_i,
    input  fetch_pkg::addr_t ex_alu_res_i,
    input  fetch_pkg::addr_t mtvec_i,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output bus_pkg::wb_adr_t wb_adr_o,
    input  bus_pkg::wb_dat_t wb_dat_i,
    input  logic             wb_ack_i,
    input  logic             stall_i,
    output fetch_pkg::inst_t inst_o,
    output fetch_pkg::addr_t inst_pc_o,
    output logic             inst_valid_o
);

    fetch_req_if req_if ();
    fetch_rsp_if rsp_if ();

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .jal_i        (jal_i),
        .branch_i     (branch_i),
        .jalr_i       (jalr_i),
        .trap_i       (trap_i),
        .ex_pc_i      (ex_pc_i),
        .ex_imm_i     (ex_imm_i),
        .ex_rs1_i     (ex_rs1_i),
        .ex_alu_res_i (ex_alu_res_i),
        .mtvec_i      (mtvec_i),
        .req          (req_if.source)
    );

    wb_fetch_master u_wb_fetch_master (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req      (req_if.sink),
        .rsp      (rsp_if.source),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    fetch_out u_fetch_out (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .rsp          (rsp_if.sink),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_valid_o (inst_valid_o)
    );

endmodule

// ==== tests/ifetch_props.sv ====
module ifetch_props (
    input logic             clk,
    input logic             rst_n_i,
    input logic             wb_cyc_o,
    input logic             wb_stb_o,
    input bus_pkg::wb_adr_t wb_adr_o,
    input logic             wb_ack_i,
    input logic             stall_i,
    input fetch_pkg::inst_t inst_o,
    input fetch_pkg::addr_t inst_pc_o,
    input logic             inst_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed properties
    int fail_count = 0;

    // single transfer per classic cycle, stb tracks cyc
    stb_matches_cyc: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_stb_o == wb_cyc_o)
        else begin
            $error("wb_stb_o differs from wb_cyc_o");
            fail_count++;
        end

    // address held until the slave acks
    adr_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_cyc_o && !wb_ack_i) |=> $stable(wb_adr_o))
        else begin
            $error("wb_adr_o changed inside a bus cycle");
            fail_count++;
        end

    valid_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(inst_valid_o))
        else begin
            $error("inst_valid_o changed under stall");
            fail_count++;
        end

    // held entry must not be overwritten
    data_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_i && inst_valid_o) |=> ($stable(inst_o) && $stable(inst_pc_o)))
        else begin
            $error("inst_o or inst_pc_o changed under stall");
            fail_count++;
        end

endmodule

// ==== tests/ifetch_tb.sv ====
module ifetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NT       = 8;
    localparam int          COLS     = 10;
    localparam logic [63:0] START_PC = 64'h8000_0000;

    logic             clk;
    logic             rst_n_i;
    logic             jal_i;
    logic             branch_i;
    logic             jalr_i;
    logic             trap_i;
    fetch_pkg::addr_t ex_pc_i;
    fetch_pkg::addr_t ex_imm_i;
    fetch_pkg::addr_t ex_rs1_i;
    fetch_pkg::addr_t ex_alu_res_i;
    fetch_pkg::addr_t mtvec_i;
    logic             wb_cyc_o;
    logic             wb_stb_o;
    bus_pkg::wb_adr_t wb_adr_o;
    bus_pkg::wb_dat_t wb_dat_i;
    logic             wb_ack_i;
    logic             stall_i;
    fetch_pkg::inst_t inst_o;
    fetch_pkg::addr_t inst_pc_o;
    logic             inst_valid_o;

    logic [63:0] tv [0:NT*COLS-1];
    int          wait_cnt;
    int          errors;
    int          failed_tests;
    int          limit_cycles;

    ifetch_top DUT (.*);

    bind ifetch_top ifetch_props u_props (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_adr_o     (wb_adr_o),
        .wb_ack_i     (wb_ack_i),
        .stall_i      (stall_i),
        .inst_o       (inst_o),
        .inst_pc_o    (inst_pc_o),
        .inst_valid_o (inst_valid_o)
    );

    always #5 clk = ~clk;

    // memory contents: each 32-bit half is its own pc scrambled
    function automatic logic [31:0] expected_inst(input logic [63:0] pc);
        return pc[31:0] ^ 32'h1357_9bdf;
    endfunction

    // slave side, 0 to 3 wait states per cycle
    task automatic serve_bus();
        if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
            if (wait_cnt == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = {expected_inst(wb_adr_o + 64'd4), expected_inst(wb_adr_o)};
                wait_cnt = int'($urandom % 4);
            end else begin
                wait_cnt--;
            end
        end else begin
            wb_ack_i = 1'b0;
        end
    endtask

    task automatic run_test(input int t);
        logic [3:0]  flags;
        logic [63:0] target;
        logic [63:0] exp_pc;
        int          nb;
        int          na;
        int          stall_lvl;
        int          got;
        int          test_errs;
        flags        = tv[t*COLS][3:0];
        ex_pc_i      = tv[t*COLS+1];
        ex_imm_i     = tv[t*COLS+2];
        ex_rs1_i     = tv[t*COLS+3];
        ex_alu_res_i = tv[t*COLS+4];
        mtvec_i      = tv[t*COLS+5];
        nb           = int'(tv[t*COLS+6]);
        na           = int'(tv[t*COLS+7]);
        stall_lvl    = int'(tv[t*COLS+8]);
        target       = tv[t*COLS+9];
        got          = 0;
        test_errs    = 0;
        // every test starts again from the reset pc
        rst_n_i  = 1'b0;
        wb_ack_i = 1'b0;
        stall_i  = 1'b0;
        {trap_i, jalr_i, branch_i, jal_i} = 4'b0;
        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        // first bus cycle opens on the first edge out of reset
        @(negedge clk);
        assert (wb_cyc_o) else begin
            $display("ERROR %0t wb_cyc_o expected 1 got %b", $time, wb_cyc_o);
            test_errs++;
        end
        assert (wb_adr_o == START_PC) else begin
            $display("ERROR %0t wb_adr_o expected %h got %h", $time, START_PC, wb_adr_o);
            test_errs++;
        end
        serve_bus();
        while (got < nb + na) begin
            @(negedge clk);
            serve_bus();
            {trap_i, jalr_i, branch_i, jal_i} = 4'b0;
            stall_i = (int'($urandom % 4) < stall_lvl);
            // output is consumed on the coming edge
            if (inst_valid_o && !stall_i) begin
                exp_pc = (got < nb) ? START_PC + 64'(4 * got) : target + 64'(4 * (got - nb));
                assert (inst_pc_o == exp_pc) else begin
                    $display("ERROR %0t inst_pc_o expected %h got %h", $time, exp_pc, inst_pc_o);
                    test_errs++;
                end
                assert (inst_o == expected_inst(exp_pc)) else begin
                    $display("ERROR %0t inst_o expected %h got %h", $time,
                             expected_inst(exp_pc), inst_o);
                    test_errs++;
                end
                got++;
                // redirect on the same edge, so nothing older reaches the output
                if (got == nb) begin
                    {trap_i, jalr_i, branch_i, jal_i} = flags;
                end
            end
        end
        errors += test_errs;
        if (test_errs != 0) begin
            failed_tests++;
        end
        $display("test %0d flags %h outputs %0d %s", t, flags, got,
                 (test_errs == 0) ? "pass" : "FAIL");
    endtask

    initial begin
        int total;
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        jal_i        = 1'b0;
        branch_i     = 1'b0;
        jalr_i       = 1'b0;
        trap_i       = 1'b0;
        ex_pc_i      = '0;
        ex_imm_i     = '0;
        ex_rs1_i     = '0;
        ex_alu_res_i = '0;
        mtvec_i      = '0;
        wb_dat_i     = '0;
        wb_ack_i     = 1'b0;
        stall_i      = 1'b0;
        errors       = 0;
        failed_tests = 0;
        limit_cycles = 0;
        wait_cnt     = 0;
        total        = 0;
        void'($urandom(32'hcb80));
        $readmemh("tests/ifetch_tests.txt", tv);
        for (int t = 0; t < NT; t++) begin
            total += int'(tv[t*COLS+6] + tv[t*COLS+7]);
        end
        limit_cycles = total * 40 + NT * 8;
        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end
        // protocol property failures count as failed checks too
        errors += DUT.u_props.fail_count;
        $display("tests %0d, failed tests %0d, failed checks %0d", NT, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog sized from the expected output count
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, outputs stopped arriving", limit_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== build.f ====
hw/fetch_pkg.sv
hw/bus_pkg.sv
hw/fetch_ifs.sv
hw/pc_gen.sv
hw/wb_fetch_master.sv
hw/fetch_out.sv
hw/ifetch_top.sv
tests/ifetch_props.sv
tests/ifetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the fetch stage testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ifetch_tb -f build.f -o ifetch_sim \
    && ./obj_dir/ifetch_sim | tee sim.log \
    || echo "build or run did not complete"

grep -q "^No errors$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tests/ifetch_tests.txt ====
// flags (jal=1 branch=2 jalr=4 trap=8), ex_pc, imm, rs1, alu_res, mtvec,
// outputs before redirect, outputs after, stall level 0-3, expected target; all hex
0 0 0 0 0 0 08 08 0 80000020
1 80000100 40 0 0 0 05 06 0 80000140
2 80000200 ffffffffffffffe0 0 0 0 03 06 1 800001e0
2 80000400 8 0 5 0 04 05 0 80000010
4 0 c 80000301 0 0 06 05 2 8000030c
5 80000500 20 90000000 0 0 02 05 0 80000520
8 0 0 0 0 80001000 07 05 1 80001000
0 0 0 0 0 0 0a 0a 3 80000028
